/* dg_pkg.sv */
// shared types, register map and table constants for the delay generator, imported by every module
`default_nettype none

package dg_pkg;

   // ============================================================
   // sizes
   // ============================================================
   localparam int NDELAY_PAIRS = 7;                  // push, inject, exit 0/1, gate 0/1, adc
   localparam int NPAGES       = 4;                  // protocol pages in the register bank
   localparam int NOUT         = 5;                  // active-low output lines
   localparam int TABLE_STRIDE = 8;                  // bytes per delay/width pair

   typedef logic [31:0] tick_t;                      // 100 MHz ticks
   typedef struct packed {
      tick_t delay;
      tick_t width;
   } delay_width_t;
   typedef delay_width_t [NDELAY_PAIRS-1:0] dw_table_t;
   typedef logic [1:0]  page_t;
   typedef logic [63:0] stamp_t;

   // ============================================================
   // register map
   // ============================================================
   localparam logic [31:0] MODEL_NUMBER = 32'h2021_0801;
   localparam logic [7:0] REG_INTERVAL     = 8'h00;
   localparam logic [7:0] REG_PAGE         = 8'h04; // bits 1:0 page, bit 2 view active
   localparam logic [7:0] REG_PROTOCOL     = 8'h08;
   localparam logic [7:0] REG_COMMIT       = 8'h0C;
   localparam logic [7:0] REG_T0_COUNT     = 8'h10;
   localparam logic [7:0] REG_STAMP_LO     = 8'h14;
   localparam logic [7:0] REG_STAMP_HI     = 8'h18;
   localparam logic [7:0] REG_MODEL        = 8'h1C;
   localparam logic [7:0] REG_ACT_INTERVAL = 8'h20;
   localparam logic [7:0] REG_TABLE_BASE   = 8'h40; // delay k at +8k, width k at +8k+4

endpackage

`default_nettype wire

/* dg_interval_timer.sv */
// period counter for the pulse generator, gives the next t0 and the next tick count since t0
`timescale 1ns/1ps
`default_nettype none

module dg_interval_timer import dg_pkg::*; (
   input  wire        clk100,
   input  wire        hps_fpga_reset_n,
   input  wire        restart,                       // commit restarts the period
   input  wire tick_t interval,
   output logic       t0_next,
   output tick_t      tick_count
);

   tick_t cnt;                                       // ticks since t0, current cycle

   // ============================================================
   // period end and wrap
   // ============================================================
   // the generator registers these, so both are for the following cycle
   assign t0_next    = restart || (cnt >= interval - 1'b1);
   assign tick_count = t0_next ? '0 : cnt + 1'b1;   // zero in the t0 cycle

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         cnt <= '0;                                  // first cycle out of reset is a t0
      end else begin
         cnt <= tick_count;
      end
   end

endmodule

`default_nettype wire

/* dg_pulse_generator.sv */
// active table and interval, period timer, channel comparators and the registered output lines
`timescale 1ns/1ps
`default_nettype none

module dg_pulse_generator import dg_pkg::*; #(
   parameter int RESET_INTERVAL = 100000
) (
   input  wire            clk100,
   input  wire            hps_fpga_reset_n,
   input  wire            commit,
   input  wire tick_t     commit_interval,
   input  wire dw_table_t commit_table,
   output tick_t          act_interval,
   output dw_table_t      act_table,
   output logic           t0,
   output logic [NOUT-1:0] out_n
);

   logic                    t0_next;
   tick_t                   tick_count;              // count seen in the next cycle
   dw_table_t               nxt_table;
   logic [NDELAY_PAIRS-1:0] chan;
   logic [NOUT-1:0]         out_nxt;

   dg_interval_timer u_timer (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .restart          (commit),
      .interval         (act_interval),
      .t0_next          (t0_next),
      .tick_count       (tick_count)
   );

   // the committed table already applies to the first cycle of the new period
   assign nxt_table = commit ? commit_table : act_table;

   // ============================================================
   // channel compare and output combining
   // ============================================================
   always_comb begin
      for (int k = 0; k < NDELAY_PAIRS; k++) begin
         chan[k] = (tick_count >= nxt_table[k].delay) &&
                   ((tick_count - nxt_table[k].delay) < nxt_table[k].width);
      end
   end

   assign out_nxt = ~{chan[6],                       // adc delay
                      chan[5] | chan[4],             // gate 0,1
                      chan[3] | chan[2],             // exit 0,1
                      chan[1],                       // inject
                      chan[0]};                      // push

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         act_interval <= tick_t'(RESET_INTERVAL);
         act_table    <= '0;
         t0           <= 1'b1;                       // period starts as reset is released
         out_n        <= '1;
      end else begin
         t0    <= t0_next;
         out_n <= out_nxt;                           // same stage as t0
         if (commit) begin
            act_interval <= commit_interval;
            act_table    <= commit_table;
         end
      end
   end

endmodule

`default_nettype wire

/* dg_apb_regs.sv */
// APB slave with protocol pages, staged interval, commit pulse and read-back of active settings
`timescale 1ns/1ps
`default_nettype none

module dg_apb_regs import dg_pkg::*; #(
   parameter int MIN_INTERVAL   = 1000,
   parameter int RESET_INTERVAL = 100000
) (
   input  wire            clk100,
   input  wire            hps_fpga_reset_n,
   input  wire            psel,
   input  wire            penable,
   input  wire            pwrite,
   input  wire [7:0]      paddr,
   input  wire [31:0]     pwdata,
   input  wire tick_t     act_interval,
   input  wire dw_table_t act_table,
   input  wire stamp_t    stamp,
   input  wire tick_t     t0_count,
   output logic [31:0]    prdata,
   output logic           pready,
   output logic           pslverr,
   output logic           commit,
   output tick_t          commit_interval,
   output dw_table_t      commit_table
);

   localparam logic [7:0] TABLE_END = REG_TABLE_BASE + 8'(TABLE_STRIDE * NDELAY_PAIRS);

   dw_table_t   pages [NPAGES];                      // edited protocol pages
   tick_t       staged_interval;
   logic [2:0]  page_reg;                            // bit 2 selects active view
   page_t       protocol;
   logic [7:0]  tbl_off;
   logic [2:0]  tbl_idx;
   logic        tbl_word;                            // 0 delay, 1 width
   logic        is_table;
   logic        mapped;
   logic        read_only;
   logic        wr_en;
   tick_t       view_interval;
   dw_table_t   view_table;

   // the reset period must itself respect the minimum
   if (RESET_INTERVAL < MIN_INTERVAL) begin : g_bad_reset_interval
      $error("RESET_INTERVAL below MIN_INTERVAL");
   end

   assign pready   = 1'b1;                           // never stalls
   assign tbl_off  = paddr - REG_TABLE_BASE;
   assign tbl_idx  = tbl_off[5:3];
   assign tbl_word = tbl_off[2];
   assign is_table = (paddr >= REG_TABLE_BASE) && (paddr < TABLE_END) && (paddr[1:0] == 2'b00);

   assign view_interval = page_reg[2] ? act_interval : staged_interval;
   assign view_table    = page_reg[2] ? act_table : pages[page_reg[1:0]];

   assign commit_interval = (staged_interval < tick_t'(MIN_INTERVAL)) ?
                            tick_t'(MIN_INTERVAL) : staged_interval; // clamp up
   assign commit_table    = pages[protocol];

   // ============================================================
   // address decode and read mux
   // ============================================================
   always_comb begin
      mapped    = 1'b1;
      read_only = 1'b0;
      prdata    = '0;
      case (paddr)
         REG_INTERVAL:     prdata = view_interval;
         REG_PAGE:         prdata = {29'd0, page_reg};
         REG_PROTOCOL:     prdata = {30'd0, protocol};
         REG_COMMIT:       prdata = '0;               // write-only strobe
         REG_T0_COUNT: begin
            prdata    = t0_count;
            read_only = 1'b1;
         end
         REG_STAMP_LO: begin
            prdata    = stamp[31:0];
            read_only = 1'b1;
         end
         REG_STAMP_HI: begin
            prdata    = stamp[63:32];
            read_only = 1'b1;
         end
         REG_MODEL: begin
            prdata    = MODEL_NUMBER;
            read_only = 1'b1;
         end
         REG_ACT_INTERVAL: begin
            prdata    = act_interval;
            read_only = 1'b1;
         end
         default: begin
            if (is_table) begin
               prdata = tbl_word ? view_table[tbl_idx].width : view_table[tbl_idx].delay;
            end else begin
               mapped = 1'b0;
            end
         end
      endcase
   end

   assign pslverr = psel && penable &&
                    (!mapped || (pwrite && read_only) || (pwrite && is_table && page_reg[2]));
   assign wr_en   = psel && penable && pwrite && !pslverr;

   // ============================================================
   // register writes
   // ============================================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pages           <= '{default: '0};
         staged_interval <= '0;
         page_reg        <= '0;
         protocol        <= '0;
         commit          <= 1'b0;
      end else begin
         commit <= 1'b0;                             // single-cycle pulse
         if (wr_en) begin
            case (paddr)
               REG_INTERVAL: staged_interval <= pwdata;
               REG_PAGE:     page_reg        <= pwdata[2:0];
               REG_PROTOCOL: protocol        <= pwdata[1:0];
               REG_COMMIT:   commit          <= pwdata[0];
               default: begin
                  if (tbl_word) begin
                     pages[page_reg[1:0]][tbl_idx].width <= pwdata;
                  end else begin
                     pages[page_reg[1:0]][tbl_idx].delay <= pwdata;
                  end
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* dg_t0_stamp.sv */
// free-running 100 MHz tick counter, captured as a timestamp on every t0, plus a t0 counter
`timescale 1ns/1ps
`default_nettype none

module dg_t0_stamp import dg_pkg::*; (
   input  wire  clk100,
   input  wire  hps_fpga_reset_n,
   input  wire  t0,
   output stamp_t stamp,
   output tick_t  t0_count
);

   stamp_t ticks;                                    // zero when reset is released

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         ticks    <= '0;
         stamp    <= '0;
         t0_count <= '0;
      end else begin
         ticks <= ticks + 1'b1;
         if (t0) begin
            stamp    <= ticks;                       // value of the t0 cycle
            t0_count <= t0_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* dg_top.sv */
// delay generator top level, joins the APB register bank, the pulse generator and the stamp unit
`timescale 1ns/1ps
`default_nettype none

module dg_top import dg_pkg::*; #(
   parameter int MIN_INTERVAL   = 1000,              // 10 us floor
   parameter int RESET_INTERVAL = 100000             // 1 ms after reset
) (
   input  wire             clk100,
   input  wire             hps_fpga_reset_n,
   input  wire             psel,
   input  wire             penable,
   input  wire             pwrite,
   input  wire [7:0]       paddr,
   input  wire [31:0]      pwdata,
   output wire [31:0]      prdata,
   output wire             pready,
   output wire             pslverr,
   output wire             t0,
   output wire [NOUT-1:0]  out_n
);

   wire            commit;
   wire tick_t     commit_interval;
   wire dw_table_t commit_table;
   wire tick_t     act_interval;
   wire dw_table_t act_table;
   wire stamp_t    stamp;
   wire tick_t     t0_count;

   dg_apb_regs #(
      .MIN_INTERVAL   (MIN_INTERVAL),
      .RESET_INTERVAL (RESET_INTERVAL)
   ) u_regs (
      .clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata),
      .act_interval (act_interval), .act_table (act_table),
      .stamp (stamp), .t0_count (t0_count),
      .prdata (prdata), .pready (pready), .pslverr (pslverr),
      .commit (commit), .commit_interval (commit_interval), .commit_table (commit_table)
   );

   dg_pulse_generator #(.RESET_INTERVAL (RESET_INTERVAL)) u_gen (
      .clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n),
      .commit (commit), .commit_interval (commit_interval), .commit_table (commit_table),
      .act_interval (act_interval), .act_table (act_table), .t0 (t0), .out_n (out_n)
   );

   dg_t0_stamp u_stamp (
      .clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n),
      .t0 (t0), .stamp (stamp), .t0_count (t0_count)
   );

endmodule

`default_nettype wire

/* tb_clock.sv */
// 100 MHz clock and reset source for the delay generator testbench, reset held for 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk100,
   output logic hps_fpga_reset_n
);

   initial begin
      clk100 = 1'b0;
      forever #5 clk100 = ~clk100;                   // 10 ns period
   end

   initial begin
      hps_fpga_reset_n = 1'b0;
      repeat (5) @(posedge clk100);
      @(negedge clk100);                             // release on the falling edge
      hps_fpga_reset_n = 1'b1;
   end

endmodule

`default_nettype wire

/* dg_checker.sv */
// concurrent assertions on t0 and the APB slave, bound into the delay generator top level
`timescale 1ns/1ps
`default_nettype none

module dg_checker (
   input wire clk100,
   input wire hps_fpga_reset_n,
   input wire psel,
   input wire penable,
   input wire pready,
   input wire pslverr,
   input wire commit,
   input wire t0
);

   int unsigned fail_count = 0;

   // a commit restarts the period, so t0 may repeat right after one
   a_t0_single: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      (t0 && !commit) |=> !t0)
      else begin
         $error("t0 stayed high for more than one cycle");
         fail_count++;
      end

   a_pready_high: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      pready)
      else begin
         $error("pready dropped low");
         fail_count++;
      end

   a_pslverr_access: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      pslverr |-> (psel && penable))
      else begin
         $error("pslverr raised outside an access cycle");
         fail_count++;
      end

endmodule

`default_nettype wire

/* dg_tb.sv */
// testbench for the delay generator, runs a stimulus table over APB and checks pins and stamps
`timescale 1ns/1ps
`default_nettype none

module dg_tb import dg_pkg::*; ();

   localparam int MIN_IVL   = 16;
   localparam int RESET_IVL = 40;
   localparam int PULSE_IVL = 48;                    // interval for pulse and stamp tests

   typedef enum {OP_WRITE, OP_WRITE_ERR, OP_READ, OP_READ_ERR, OP_OUT, OP_T0_GAP, OP_PULSES,
                 OP_STAMP} op_t;
   typedef struct {
      op_t        op;
      logic [7:0] addr;
      tick_t      data;                              // page number for OP_PULSES
      tick_t      expected;                          // interval for timed rows
   } row_t;

   wire             clk100;
   wire             hps_fpga_reset_n;
   logic            psel;
   logic            penable;
   logic            pwrite;
   logic [7:0]      paddr;
   logic [31:0]     pwdata;
   wire  [31:0]     prdata;
   wire             pready;
   wire             pslverr;
   wire             t0;
   wire  [NOUT-1:0] out_n;

   row_t  rows [$];
   tick_t model [NPAGES][2*NDELAY_PAIRS];            // expected page contents
   tick_t rng_state   = 32'h8141;
   int    budget      = 0;
   int    cycle_limit = 0;
   int    cycles      = 0;

   tb_clock u_clock (.clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n));

   dg_top #(.MIN_INTERVAL (MIN_IVL), .RESET_INTERVAL (RESET_IVL)) dut (
      .clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata),
      .prdata (prdata), .pready (pready), .pslverr (pslverr), .t0 (t0), .out_n (out_n)
   );

   bind dg_top dg_checker u_checker (
      .clk100 (clk100), .hps_fpga_reset_n (hps_fpga_reset_n), .psel (psel),
      .penable (penable), .pready (pready), .pslverr (pslverr), .commit (commit), .t0 (t0)
   );

   // ============================================================
   // reference model and checks
   // ============================================================
   function automatic tick_t lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [7:0] table_addr(input int i);
      return REG_TABLE_BASE + 8'(4 * i);             // even i delay, odd i width
   endfunction

   function automatic logic [NOUT-1:0] expected_out(input int page, input tick_t tick);
      logic [NDELAY_PAIRS-1:0] ch;
      for (int k = 0; k < NDELAY_PAIRS; k++) begin
         ch[k] = (tick >= model[page][2*k]) && (tick < model[page][2*k] + model[page][2*k+1]);
      end
      return ~{ch[6], ch[5] | ch[4], ch[3] | ch[2], ch[1], ch[0]};
   endfunction

   task automatic halt_failed(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input tick_t got, input tick_t exp);
      if (got !== exp) begin
         halt_failed($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_stamp(input string name, input stamp_t got, input stamp_t exp);
      if (got !== exp) begin
         halt_failed($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_out(input string name, input logic [NOUT-1:0] got,
                            input logic [NOUT-1:0] exp);
      if (got !== exp) begin
         halt_failed($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
      end
   endtask

   // ============================================================
   // bus and timing tasks
   // ============================================================
   task automatic apb_access(input logic write, input logic [7:0] addr, input tick_t wdata,
                             output tick_t rdata, output logic err);
      @(negedge clk100);
      psel    = 1'b1;                                // setup cycle
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk100);
      penable = 1'b1;                                // access cycle
      #2;
      rdata = prdata;
      err   = pslverr;
      @(negedge clk100);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input tick_t data, output logic err);
      tick_t unused;
      apb_access(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [7:0] addr, output tick_t data, output logic err);
      apb_access(1'b0, addr, '0, data, err);
   endtask

   task automatic read_expect_ok(input logic [7:0] addr, output tick_t data);
      logic err;
      apb_read(addr, data, err);
      check_word($sformatf("pslverr @%h", addr), tick_t'(err), 0);
   endtask

   task automatic wait_t0();
      @(negedge clk100);
      while (t0 !== 1'b1) begin
         @(negedge clk100);
      end
   endtask

   task automatic check_t0_gap(input tick_t interval);
      tick_t gap;
      wait_t0();
      gap = 0;
      do begin
         @(negedge clk100);
         gap++;
      end while (t0 !== 1'b1);
      check_word("t0 spacing", gap, interval);
   endtask

   task automatic check_pulses(input int page, input tick_t interval);
      tick_t tick;
      wait_t0();
      for (int c = 0; c < 2 * interval; c++) begin
         if (c > 0) begin
            @(negedge clk100);
         end
         tick = c % interval;                        // zero in the t0 cycle
         check_word("t0", tick_t'(t0), tick_t'(tick == 0));
         check_out("out_n", out_n, expected_out(page, tick));
      end
   endtask

   task automatic check_stamps(input tick_t interval);
      tick_t  lo;
      tick_t  hi;
      tick_t  count0;
      tick_t  count1;
      stamp_t stamp0;
      wait_t0();
      read_expect_ok(REG_STAMP_LO, lo);
      read_expect_ok(REG_STAMP_HI, hi);
      read_expect_ok(REG_T0_COUNT, count0);
      stamp0 = {hi, lo};
      wait_t0();
      read_expect_ok(REG_STAMP_LO, lo);
      read_expect_ok(REG_STAMP_HI, hi);
      read_expect_ok(REG_T0_COUNT, count1);
      check_stamp("stamp delta", {hi, lo} - stamp0, stamp_t'(interval));
      check_word("t0_count delta", count1 - count0, 1);
   endtask

   task automatic run_row(input row_t r);
      tick_t rdata;
      logic  err;
      case (r.op)
         OP_WRITE, OP_WRITE_ERR: begin
            apb_write(r.addr, r.data, err);
            check_word($sformatf("pslverr @%h", r.addr), tick_t'(err),
                       tick_t'(r.op == OP_WRITE_ERR));
         end
         OP_READ, OP_READ_ERR: begin
            apb_read(r.addr, rdata, err);
            check_word($sformatf("pslverr @%h", r.addr), tick_t'(err),
                       tick_t'(r.op == OP_READ_ERR));
            if (r.op == OP_READ) begin
               check_word($sformatf("prdata @%h", r.addr), rdata, r.expected);
            end
         end
         OP_OUT: begin
            @(negedge clk100);
            check_out("out_n", out_n, r.expected[NOUT-1:0]);
         end
         OP_T0_GAP: check_t0_gap(r.expected);
         OP_PULSES: check_pulses(int'(r.data), r.expected);
         OP_STAMP:  check_stamps(r.expected);
         default:   halt_failed("unknown operation in the stimulus table");
      endcase
   endtask

   // ============================================================
   // stimulus table
   // ============================================================
   task automatic add_row(input op_t op, input logic [7:0] addr, input tick_t data,
                          input tick_t expected);
      row_t r;
      r.op       = op;
      r.addr     = addr;
      r.data     = data;
      r.expected = expected;
      rows.push_back(r);
      case (op)
         OP_T0_GAP, OP_PULSES: budget += 3 * expected;
         OP_STAMP:             budget += 3 * expected + 20;
         default:              budget += 4;
      endcase
   endtask

   task automatic add_page_writes(input int page);
      add_row(OP_WRITE, REG_PAGE, page, 0);
      for (int i = 0; i < 2 * NDELAY_PAIRS; i++) begin
         model[page][i] = (lcg_next() >> 8) % PULSE_IVL;   // stays inside a period
         add_row(OP_WRITE, table_addr(i), model[page][i], 0);
      end
   endtask

   task automatic add_page_reads(input int page);
      for (int i = 0; i < 2 * NDELAY_PAIRS; i++) begin
         add_row(OP_READ, table_addr(i), 0, model[page][i]);
      end
   endtask

   task automatic build_rows();
      int rp;
      model = '{default: '0};
      add_row(OP_OUT, 8'h00, 0, 32'h1F);             // state after reset
      add_row(OP_READ, REG_MODEL, 0, MODEL_NUMBER);
      add_row(OP_READ, REG_ACT_INTERVAL, 0, RESET_IVL);
      add_row(OP_READ, REG_INTERVAL, 0, 0);
      add_row(OP_READ, REG_COMMIT, 0, 0);
      for (int p = 0; p < NPAGES; p++) begin
         add_row(OP_WRITE, REG_PAGE, p, 0);
         add_page_reads(p);
      end
      for (int p = 0; p < NPAGES; p++) begin
         add_page_writes(p);
      end
      for (int p = 0; p < NPAGES; p++) begin
         add_row(OP_WRITE, REG_PAGE, p, 0);
         add_page_reads(p);
      end
      add_row(OP_READ_ERR, 8'h24, 0, 0);             // refused accesses, page 3 selected
      add_row(OP_READ_ERR, table_addr(2 * NDELAY_PAIRS), 0, 0);
      add_row(OP_WRITE_ERR, 8'h3C, 32'hFFFF_FFFF, 0);
      add_row(OP_WRITE_ERR, REG_TABLE_BASE + 8'h02, 32'hFFFF_FFFF, 0);
      add_row(OP_WRITE_ERR, REG_MODEL, 1, 0);
      add_row(OP_WRITE_ERR, REG_T0_COUNT, 1, 0);
      add_row(OP_WRITE_ERR, REG_STAMP_LO, 1, 0);
      add_row(OP_WRITE_ERR, REG_ACT_INTERVAL, 1, 0);
      add_row(OP_WRITE, REG_PAGE, 32'h7, 0);
      add_row(OP_WRITE_ERR, table_addr(0), 32'hDEAD_BEEF, 0);
      add_row(OP_WRITE_ERR, table_addr(13), 32'hDEAD_BEEF, 0);
      add_row(OP_READ, REG_MODEL, 0, MODEL_NUMBER);
      add_row(OP_READ, REG_ACT_INTERVAL, 0, RESET_IVL);
      add_row(OP_WRITE, REG_PAGE, 3, 0);
      add_row(OP_READ, REG_INTERVAL, 0, 0);          // staged interval untouched
      add_page_reads(3);
      add_row(OP_WRITE, REG_INTERVAL, 5, 0);         // below the floor
      add_row(OP_WRITE, REG_COMMIT, 1, 0);
      add_row(OP_READ, REG_ACT_INTERVAL, 0, MIN_IVL);
      add_row(OP_READ, REG_INTERVAL, 0, 5);
      add_row(OP_T0_GAP, 8'h00, 0, MIN_IVL);
      add_row(OP_WRITE, REG_INTERVAL, PULSE_IVL, 0);
      add_row(OP_WRITE, REG_COMMIT, 1, 0);
      add_row(OP_READ, REG_ACT_INTERVAL, 0, PULSE_IVL);
      add_row(OP_T0_GAP, 8'h00, 0, PULSE_IVL);
      rp = int'(lcg_next() >> 8) % NPAGES;
      add_row(OP_WRITE, REG_PROTOCOL, rp, 0);
      add_row(OP_WRITE, REG_COMMIT, 1, 0);
      add_row(OP_PULSES, 8'h00, rp, PULSE_IVL);
      add_row(OP_STAMP, 8'h00, 0, PULSE_IVL);
      add_row(OP_WRITE, REG_PAGE, 4 | ((rp + 1) % NPAGES), 0);   // active view
      add_row(OP_WRITE, REG_INTERVAL, 100, 0);
      add_row(OP_READ, REG_INTERVAL, 0, PULSE_IVL);
      add_page_reads(rp);
      add_row(OP_WRITE, REG_PAGE, 4 | ((rp + 2) % NPAGES), 0);
      add_page_reads(rp);
      add_row(OP_WRITE, REG_PAGE, (rp + 2) % NPAGES, 0);
      add_row(OP_READ, REG_INTERVAL, 0, 100);
   endtask

   always @(posedge clk100) begin
      cycles++;
      if (cycles > cycle_limit) begin
         halt_failed("timeout: the test ran past its cycle limit without finishing");
      end
      if (dut.u_checker.fail_count != 0) begin
         halt_failed("a bound assertion on t0 or the APB slave failed");
      end
   end

   initial begin
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_rows();
      cycle_limit = 2 * budget + 20;                 // reset cycles included
      wait (hps_fpga_reset_n === 1'b1);
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      @(negedge clk100);
      if (dut.u_checker.fail_count == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display(">>> FAIL");
         $fatal(1, "bound assertions reported errors");
      end
   end

endmodule

`default_nettype wire

/* list.f */
dg_pkg.sv
dg_interval_timer.sv
dg_pulse_generator.sv
dg_apb_regs.sv
dg_t0_stamp.sv
dg_top.sv
tb_clock.sv
dg_checker.sv
dg_tb.sv
